// File: build.f
hw/tcdm_pkg.sv
hw/hwce_reg_pkg.sv
hw/apb_reg_decode.sv
hw/tcdm_burst_master.sv
hw/read_accumulator.sv
hw/traffic_gen_top.sv
sim/traffic_gen_properties.sv
sim/tb_traffic_gen.sv

// File: hw/apb_reg_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB register decoder
// Turns APB write accesses into start and accumulator
// strobes and forms read data from the status registers
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module apb_reg_decode (
  input  hwce_reg_pkg::apb_req_t                      apb_i,
  output logic [hwce_reg_pkg::APB_DATA_W-1:0]         prdata_o,

  output logic [1:0]                                  start_o,
  output logic [hwce_reg_pkg::APB_DATA_W-1:0]         start_data_o,
  output logic                                        accum_we_o,

  input  logic [1:0]                                  done_i,
  input  logic [31:0]                                 accum_i
);

  logic access;
  logic wr_access;
  logic rd_access;

  logic is_start0;
  logic is_start1;
  logic is_done0;
  logic is_done1;
  logic is_accum;

  // access phase, pready is always high so every access completes here
  assign access    = apb_i.psel & apb_i.penable;
  assign wr_access = access & apb_i.pwrite;
  assign rd_access = access & ~apb_i.pwrite;

  assign is_start0 = apb_i.paddr == hwce_reg_pkg::REG_START0;
  assign is_start1 = apb_i.paddr == hwce_reg_pkg::REG_START1;
  assign is_done0  = apb_i.paddr == hwce_reg_pkg::REG_DONE0;
  assign is_done1  = apb_i.paddr == hwce_reg_pkg::REG_DONE1;
  assign is_accum  = apb_i.paddr == hwce_reg_pkg::REG_ACCUM;

  // one cycle strobes, taken by the targets at the same edge
  assign start_o[0] = wr_access & is_start0;
  assign start_o[1] = wr_access & is_start1;
  assign accum_we_o = wr_access & is_accum;

  // shared write data, base address for starts and value for the accumulator
  assign start_data_o = apb_i.pwdata;

  // read mux
  // write-only and unmapped offsets return zero, as does any non-read cycle
  always_comb begin
    prdata_o = '0;
    if (rd_access) begin
      if (is_done0) begin
        prdata_o = hwce_reg_pkg::APB_DATA_W'(done_i[0]);
      end else if (is_done1) begin
        prdata_o = hwce_reg_pkg::APB_DATA_W'(done_i[1]);
      end else if (is_accum) begin
        prdata_o = accum_i;
      end
    end
  end

endmodule

// File: hw/hwce_reg_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB register interface of the traffic generator
// Bus widths, the APB request struct and the word offsets
// of the control and status registers
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package hwce_reg_pkg;

  localparam int unsigned APB_ADDR_W = 7;  // word index, not byte address
  localparam int unsigned APB_DATA_W = 32;

  // 42 bits, pready is implicit and always high
  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  // start registers, write only
  // the written word is the base byte address of the burst
  localparam logic [APB_ADDR_W-1:0] REG_START0 = 7'h0;  // byte 0x00
  localparam logic [APB_ADDR_W-1:0] REG_START1 = 7'h1;  // byte 0x04

  // done registers, read only, bit 0 is the flag
  localparam logic [APB_ADDR_W-1:0] REG_DONE0 = 7'h4;  // byte 0x10
  localparam logic [APB_ADDR_W-1:0] REG_DONE1 = 7'h5;  // byte 0x14

  // read data accumulator of port 1
  localparam logic [APB_ADDR_W-1:0] REG_ACCUM = 7'hE;  // byte 0x38

endpackage

// File: hw/read_accumulator.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read data accumulator
// Sums every returned read word modulo 2^32; software can
// read the sum and overwrite it over APB
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module read_accumulator (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  input  logic                             beat_i,   // one per accepted r_valid
  input  logic [tcdm_pkg::TCDM_DATA_W-1:0] rdata_i,

  input  logic                             we_i,
  input  logic [31:0]                      wdata_i,

  output logic [31:0]                      accum_o
);

  logic [31:0] accum_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accum_q <= '0;
    end else if (we_i) begin
      accum_q <= wdata_i;  // software write beats a same-cycle beat
    end else if (beat_i) begin
      accum_q <= accum_q + rdata_i;  // wraps
    end
  end

  assign accum_o = accum_q;

endmodule

// File: hw/tcdm_burst_master.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TCDM burst master
// Issues 2^BURST_LEN_LOG2 single-word accesses to
// consecutive word addresses from a latched base, with at
// most one request outstanding, and flags the burst end
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tcdm_burst_master #(
  parameter int unsigned BURST_LEN_LOG2 = 6,
  parameter bit          IS_WRITE       = 1'b0  // write beats carry their index
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  input  logic                             start_i,
  input  logic [tcdm_pkg::TCDM_ADDR_W-1:0] base_i,

  output tcdm_pkg::tcdm_req_t              tcdm_req_o,
  input  tcdm_pkg::tcdm_rsp_t              tcdm_rsp_i,

  output logic                             done_o,
  output logic                             beat_o,
  output logic                             done_event_o
);

  // msb of the counter marks that all beats have been granted
  localparam int unsigned CNT_W = BURST_LEN_LOG2 + 1;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID
  } state_e;

  state_e                           state_d, state_q;
  logic [CNT_W-1:0]                 count_q;
  logic                             count_inc;
  logic                             last_beat;
  logic                             done_d, done_q;
  logic [tcdm_pkg::TCDM_ADDR_W-1:0] base_q;
  logic [BURST_LEN_LOG2-1:0]        beat_idx;

  assign beat_idx  = count_q[BURST_LEN_LOG2-1:0];
  assign last_beat = count_q[CNT_W-1];

  always_comb begin
    state_d        = state_q;
    done_d         = 1'b0;
    count_inc      = 1'b0;
    tcdm_req_o.req = 1'b0;
    beat_o         = 1'b0;
    done_event_o   = 1'b0;

    unique case (state_q)
      IDLE: begin
        done_d = 1'b1;
        if (start_i) begin
          done_d  = 1'b0;
          state_d = WAIT_GNT;
        end
      end

      WAIT_GNT: begin
        tcdm_req_o.req = 1'b1;  // held with stable address until granted
        if (tcdm_rsp_i.gnt) begin
          count_inc = 1'b1;
          state_d   = WAIT_RVALID;
        end
      end

      WAIT_RVALID: begin
        if (tcdm_rsp_i.r_valid) begin
          beat_o = 1'b1;
          if (last_beat) begin
            done_d       = 1'b1;
            done_event_o = 1'b1;
            state_d      = IDLE;
          end else begin
            // next request goes out in the same cycle as the response
            tcdm_req_o.req = 1'b1;
            if (tcdm_rsp_i.gnt) begin
              count_inc = 1'b1;
            end else begin
              state_d = WAIT_GNT;
            end
          end
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      done_q  <= 1'b1;
      count_q <= '0;
      base_q  <= '0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
      if (state_q == IDLE && start_i) begin
        base_q  <= base_i;  // busy engines keep their base
        count_q <= '0;
      end else if (count_inc) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  assign tcdm_req_o.addr  = base_q + tcdm_pkg::TCDM_ADDR_W'({beat_idx, 2'b00});
  assign tcdm_req_o.wen   = ~IS_WRITE;
  assign tcdm_req_o.wdata = IS_WRITE ? tcdm_pkg::TCDM_DATA_W'(beat_idx) : '0;

  assign done_o = done_q;

endmodule

// File: hw/tcdm_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TCDM port definitions
// Widths plus the request and response structs that are
// shared by every burst master port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package tcdm_pkg;

  localparam int unsigned TCDM_ADDR_W = 20;  // byte address
  localparam int unsigned TCDM_DATA_W = 32;

  // master to memory, 54 bits
  typedef struct packed {
    logic                   req;
    logic [TCDM_ADDR_W-1:0] addr;
    logic                   wen;    // low for write
    logic [TCDM_DATA_W-1:0] wdata;
  } tcdm_req_t;

  // memory to master, 34 bits
  typedef struct packed {
    logic                   gnt;
    logic                   r_valid;
    logic [TCDM_DATA_W-1:0] r_rdata;
  } tcdm_rsp_t;

endpackage

// File: hw/traffic_gen_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TCDM traffic generator
// APB controlled write burst on port 0 and read burst on
// port 1, with a running sum of the port 1 read data
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module traffic_gen_top #(
  parameter int unsigned BURST_LEN_LOG2 = 6
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  input  hwce_reg_pkg::apb_req_t              apb_i,
  output logic [hwce_reg_pkg::APB_DATA_W-1:0] apb_prdata_o,

  output tcdm_pkg::tcdm_req_t                 tcdm0_req_o,
  input  tcdm_pkg::tcdm_rsp_t                 tcdm0_rsp_i,
  output tcdm_pkg::tcdm_req_t                 tcdm1_req_o,
  input  tcdm_pkg::tcdm_rsp_t                 tcdm1_rsp_i,

  output logic [1:0]                          events_o
);

  logic [1:0]                          start;
  logic [hwce_reg_pkg::APB_DATA_W-1:0] start_data;
  logic                                accum_we;
  logic [1:0]                          done;
  logic [31:0]                         accum;
  logic                                beat1;

  apb_reg_decode apb_reg_decode_inst (
    .apb_i        (apb_i),
    .prdata_o     (apb_prdata_o),
    .start_o      (start),
    .start_data_o (start_data),
    .accum_we_o   (accum_we),
    .done_i       (done),
    .accum_i      (accum)
  );

  // port 0, write burst
  tcdm_burst_master #(
    .BURST_LEN_LOG2 (BURST_LEN_LOG2),
    .IS_WRITE       (1'b1)
  ) tcdm_burst_master_wr_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start[0]),
    .base_i       (start_data[tcdm_pkg::TCDM_ADDR_W-1:0]),
    .tcdm_req_o   (tcdm0_req_o),
    .tcdm_rsp_i   (tcdm0_rsp_i),
    .done_o       (done[0]),
    .beat_o       (),  // write responses carry no data
    .done_event_o (events_o[0])
  );

  // port 1, read burst
  tcdm_burst_master #(
    .BURST_LEN_LOG2 (BURST_LEN_LOG2),
    .IS_WRITE       (1'b0)
  ) tcdm_burst_master_rd_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start[1]),
    .base_i       (start_data[tcdm_pkg::TCDM_ADDR_W-1:0]),
    .tcdm_req_o   (tcdm1_req_o),
    .tcdm_rsp_i   (tcdm1_rsp_i),
    .done_o       (done[1]),
    .beat_o       (beat1),
    .done_event_o (events_o[1])
  );

  read_accumulator read_accumulator_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .beat_i  (beat1),
    .rdata_i (tcdm1_rsp_i.r_rdata),
    .we_i    (accum_we),
    .wdata_i (start_data),
    .accum_o (accum)
  );

endmodule

// File: sim/tb_traffic_gen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Traffic generator testbench
// APB driver, randomized TCDM memory on both ports and a
// reference model for addresses, data, events and the sum
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_traffic_gen;

  localparam int unsigned SEED           = 99862;
  localparam int unsigned CLK_PERIOD     = 10;
  localparam int unsigned BURST_LEN_LOG2 = 6;
  localparam int unsigned BURST_LEN      = 1 << BURST_LEN_LOG2;
  localparam int unsigned BEAT_MAX_CYC   = 8;  // gnt wait 3, grant 1, r_valid wait 3
  localparam int unsigned N_BURSTS       = 4;
  localparam int unsigned TIMEOUT_NS =
    2 * (N_BURSTS * BURST_LEN * BEAT_MAX_CYC + 300) * CLK_PERIOD;

  typedef struct packed {
    logic                             port;
    logic [tcdm_pkg::TCDM_ADDR_W-1:0] addr;
    logic                             wen;
    logic [tcdm_pkg::TCDM_DATA_W-1:0] wdata;
  } grant_t;

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  hwce_reg_pkg::apb_req_t apb;
  logic [31:0]            prdata;
  tcdm_pkg::tcdm_req_t    req [2];
  tcdm_pkg::tcdm_rsp_t    rsp [2];
  logic [1:0]             events;

  logic [31:0] lfsr;
  grant_t      grant_q[$];  // every handshake seen on either port
  int          gnt_wait [2];
  int          rv_wait [2];
  logic        pend [2];  // one response owed
  logic [31:0] rdata_next [2];
  int          ev_cnt [2];
  logic [31:0] rd_sum;  // port 1 returned data since last clear
  int          errors = 0;
  int          test_err0 = 0;
  int          n_pass = 0;
  int          n_fail = 0;

  traffic_gen_top #(
    .BURST_LEN_LOG2 (BURST_LEN_LOG2)
  ) traffic_gen_top_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .apb_i        (apb),
    .apb_prdata_o (prdata),
    .tcdm0_req_o  (req[0]),
    .tcdm0_rsp_i  (rsp[0]),
    .tcdm1_req_o  (req[1]),
    .tcdm1_rsp_i  (rsp[1]),
    .events_o     (events)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  // memory outputs change on the falling edge only
  always @(negedge clk_i) begin
    for (int p = 0; p < 2; p++) begin
      rsp[p].gnt     = (gnt_wait[p] == 0);
      rsp[p].r_valid = pend[p] && (rv_wait[p] == 0);
      rsp[p].r_rdata = rsp[p].r_valid ? rdata_next[p] : '0;
      if (pend[p] && rv_wait[p] > 0) begin
        rv_wait[p]--;
      end
    end
  end

  // handshakes are observed just before the rising edge updates the DUT
  always @(posedge clk_i) begin
    grant_t rec;
    if (rst_ni) begin
      for (int p = 0; p < 2; p++) begin
        if (rsp[p].r_valid) begin
          pend[p] = 1'b0;
          if (p == 1) begin
            rd_sum = rd_sum + rsp[p].r_rdata;
          end
        end
        if (req[p].req && rsp[p].gnt) begin
          rec.port  = p[0];
          rec.addr  = req[p].addr;
          rec.wen   = req[p].wen;
          rec.wdata = req[p].wdata;
          grant_q.push_back(rec);
          pend[p]       = 1'b1;
          rv_wait[p]    = int'(rand_bits(2) % 3);  // r_valid 1 to 3 cycles later
          gnt_wait[p]   = int'(rand_bits(2));
          rdata_next[p] = rand_bits(32);
        end else if (req[p].req) begin
          gnt_wait[p]--;
        end
        if (events[p]) begin
          ev_cnt[p]++;
        end
      end
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic apb_write(input logic [6:0] addr, input logic [31:0] data);
    @(negedge clk_i);
    apb.psel    = 1'b1;
    apb.penable = 1'b0;
    apb.pwrite  = 1'b1;
    apb.paddr   = addr;
    apb.pwdata  = data;
    @(negedge clk_i);
    apb.penable = 1'b1;
    @(posedge clk_i);
    check_val("apb_prdata_o in write access", prdata, 32'h0);
    @(negedge clk_i);
    apb = '0;
  endtask

  task automatic apb_read(input logic [6:0] addr, output logic [31:0] data);
    @(negedge clk_i);
    apb.psel    = 1'b1;
    apb.penable = 1'b0;
    apb.pwrite  = 1'b0;
    apb.paddr   = addr;
    apb.pwdata  = '0;
    @(posedge clk_i);
    check_val("apb_prdata_o in setup phase", prdata, 32'h0);
    @(negedge clk_i);
    apb.penable = 1'b1;
    @(posedge clk_i);
    data = prdata;
    @(negedge clk_i);
    apb = '0;
  endtask

  task automatic wait_burst_end(input int p, input int ev_before);
    while (ev_cnt[p] == ev_before) begin
      @(negedge clk_i);
    end
    repeat (4) @(negedge clk_i);  // room for a stray second event
  endtask

  // beat k of a burst goes to base + 4k and write beats carry k
  task automatic check_burst(input int p, input logic [19:0] base);
    int          k;
    logic [19:0] exp_addr;
    k = 0;
    foreach (grant_q[i]) begin
      if (grant_q[i].port == p[0]) begin
        exp_addr = base + 20'(4 * k);
        check_val($sformatf("tcdm%0d_req_o.addr beat %0d", p, k),
                  32'(grant_q[i].addr), 32'(exp_addr));
        check_val($sformatf("tcdm%0d_req_o.wen beat %0d", p, k),
                  32'(grant_q[i].wen), (p == 0) ? 32'h0 : 32'h1);
        check_val($sformatf("tcdm%0d_req_o.wdata beat %0d", p, k),
                  grant_q[i].wdata, (p == 0) ? 32'(k) : 32'h0);
        k++;
      end
    end
    check_val($sformatf("tcdm%0d grant count", p), k, BURST_LEN);
  endtask

  task automatic end_test(input string name);
    if (errors == test_err0) begin
      n_pass++;
      $display("[%0t] %-26s pass", $time, name);
    end else begin
      n_fail++;
      $display("[%0t] %-26s FAIL, %0d errors", $time, name, errors - test_err0);
    end
    test_err0 = errors;
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, a burst never finished", TIMEOUT_NS);
    $display("Test failed");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    logic [19:0] base0;
    logic [19:0] base1;
    logic [19:0] base_busy;
    logic [31:0] preset;
    int          ev0;
    int          ev1;
    int          prop_fails;
    lfsr   = SEED;
    rst_ni = 1'b0;
    apb    = '0;
    rd_sum = '0;
    for (int p = 0; p < 2; p++) begin
      rsp[p]        = '0;
      gnt_wait[p]   = 0;
      rv_wait[p]    = 0;
      pend[p]       = 1'b0;
      rdata_next[p] = '0;
      ev_cnt[p]     = 0;
    end
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;

    @(posedge clk_i);
    check_val("tcdm0_req_o.req", req[0].req, 32'h0);
    check_val("tcdm1_req_o.req", req[1].req, 32'h0);
    check_val("events_o", events, 32'h0);
    check_val("apb_prdata_o idle", prdata, 32'h0);
    apb_read(hwce_reg_pkg::REG_DONE0, rd);
    check_val("DONE0", rd, 32'h1);
    apb_read(hwce_reg_pkg::REG_DONE1, rd);
    check_val("DONE1", rd, 32'h1);
    apb_read(hwce_reg_pkg::REG_ACCUM, rd);
    check_val("ACCUM", rd, 32'h0);
    end_test("reset values");

    base0 = {18'(rand_bits(18)), 2'b00};
    ev0   = ev_cnt[0];
    apb_write(hwce_reg_pkg::REG_START0, 32'(base0));
    apb_read(hwce_reg_pkg::REG_DONE0, rd);
    check_val("DONE0 mid-burst", rd, 32'h0);
    wait_burst_end(0, ev0);
    apb_read(hwce_reg_pkg::REG_DONE0, rd);
    check_val("DONE0 after burst", rd, 32'h1);
    check_val("events_o[0] pulse count", ev_cnt[0] - ev0, 32'h1);
    check_burst(0, base0);
    grant_q.delete();
    end_test("port 0 write burst");

    preset = rand_bits(32);
    apb_write(hwce_reg_pkg::REG_ACCUM, preset);
    rd_sum = '0;
    base1  = {18'(rand_bits(18)), 2'b00};
    ev1    = ev_cnt[1];
    apb_write(hwce_reg_pkg::REG_START1, 32'(base1));
    wait_burst_end(1, ev1);
    apb_read(hwce_reg_pkg::REG_DONE1, rd);
    check_val("DONE1 after burst", rd, 32'h1);
    check_val("events_o[1] pulse count", ev_cnt[1] - ev1, 32'h1);
    check_burst(1, base1);
    grant_q.delete();
    apb_read(hwce_reg_pkg::REG_ACCUM, rd);
    check_val("ACCUM after read burst", rd, preset + rd_sum);
    end_test("port 1 read burst");

    preset = rand_bits(32);
    apb_write(hwce_reg_pkg::REG_ACCUM, preset);
    apb_read(hwce_reg_pkg::REG_ACCUM, rd);
    check_val("ACCUM readback", rd, preset);
    apb_read(7'h2, rd);
    check_val("unmapped 0x2", rd, 32'h0);
    apb_read(7'h7F, rd);
    check_val("unmapped 0x7F", rd, 32'h0);
    apb_read(hwce_reg_pkg::REG_START0, rd);
    check_val("START0 read", rd, 32'h0);
    @(posedge clk_i);
    check_val("apb_prdata_o idle", prdata, 32'h0);
    end_test("accumulator access");

    base0     = {18'(rand_bits(18)), 2'b00};
    base1     = {18'(rand_bits(18)), 2'b00};
    base_busy = {18'(rand_bits(18)), 2'b00};
    preset    = rand_bits(32);
    apb_write(hwce_reg_pkg::REG_ACCUM, preset);
    rd_sum = '0;
    ev0    = ev_cnt[0];
    ev1    = ev_cnt[1];
    apb_write(hwce_reg_pkg::REG_START0, 32'(base0));
    apb_write(hwce_reg_pkg::REG_START1, 32'(base1));
    repeat (10) @(negedge clk_i);
    apb_read(hwce_reg_pkg::REG_DONE0, rd);
    check_val("DONE0 before restart", rd, 32'h0);
    // both engines are busy so these starts must be ignored
    apb_write(hwce_reg_pkg::REG_START0, 32'(base_busy));
    apb_write(hwce_reg_pkg::REG_START1, 32'(base_busy));
    wait_burst_end(0, ev0);
    wait_burst_end(1, ev1);
    check_val("events_o[0] pulse count", ev_cnt[0] - ev0, 32'h1);
    check_val("events_o[1] pulse count", ev_cnt[1] - ev1, 32'h1);
    check_burst(0, base0);
    check_burst(1, base1);
    grant_q.delete();
    apb_read(hwce_reg_pkg::REG_ACCUM, rd);
    check_val("ACCUM after concurrent bursts", rd, preset + rd_sum);
    end_test("start while busy");

    prop_fails = traffic_gen_top_inst.traffic_gen_properties_inst.fail_cnt;
    $display("tests: %0d passed, %0d failed, %0d check errors, %0d property failures",
             n_pass, n_fail, errors, prop_fails);
    if (n_fail == 0 && prop_fails == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: sim/traffic_gen_properties.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Traffic generator protocol properties
// Request hold until grant, single-cycle end events and
// no traffic while an engine reports done
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module traffic_gen_properties (
  input logic                clk_i,
  input logic                rst_ni,
  input tcdm_pkg::tcdm_req_t req0_i,
  input tcdm_pkg::tcdm_rsp_t rsp0_i,
  input tcdm_pkg::tcdm_req_t req1_i,
  input tcdm_pkg::tcdm_rsp_t rsp1_i,
  input logic [1:0]          events_i,
  input logic [1:0]          done_i
);

  int unsigned fail_cnt = 0;  // failed property count

  // an ungranted request stays up with the same address and data
  req_hold0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req0_i.req && !rsp0_i.gnt |=> req0_i.req && $stable(req0_i.addr) && $stable(req0_i.wdata))
    else begin
      $error("port 0 request dropped or changed before its grant");
      fail_cnt++;
    end

  req_hold1: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req1_i.req && !rsp1_i.gnt |=> req1_i.req && $stable(req1_i.addr))
    else begin
      $error("port 1 request dropped or changed before its grant");
      fail_cnt++;
    end

  event_pulse0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    events_i[0] |=> !events_i[0])
    else begin
      $error("port 0 end event longer than one cycle");
      fail_cnt++;
    end

  event_pulse1: assert property (@(posedge clk_i) disable iff (!rst_ni)
    events_i[1] |=> !events_i[1])
    else begin
      $error("port 1 end event longer than one cycle");
      fail_cnt++;
    end

  // an idle engine keeps its port quiet
  idle_quiet0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i[0] |-> !req0_i.req)
    else begin
      $error("port 0 request while done is set");
      fail_cnt++;
    end

  idle_quiet1: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i[1] |-> !req1_i.req)
    else begin
      $error("port 1 request while done is set");
      fail_cnt++;
    end

endmodule

bind traffic_gen_top traffic_gen_properties traffic_gen_properties_inst (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .req0_i   (tcdm0_req_o),
  .rsp0_i   (tcdm0_rsp_i),
  .req1_i   (tcdm1_req_o),
  .rsp1_i   (tcdm1_rsp_i),
  .events_i (events_o),
  .done_i   (done)
);
